// ==== source/la_defs.svh ====
// logic analyzer sizing and header byte constants, included by the packages and the RTL
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// input channels, one sample word per capture
`define LA_CHLS 32

// divisor width, three command bytes
`define LA_DIV_W 24

// fifo address width, 8 entries
`define LA_FIFO_AW 3

// header bytes in front of each sample
`define LA_HDR_OK 8'h5A   // normal sample
`define LA_HDR_GAP 8'h5B  // first sample after a drop

`endif

// ==== source/la_cfg_pkg.sv ====
// configuration side types shared by the command decoder and the sampler
`include "la_defs.svh"

package la_cfg_pkg;

  // divisor as received, first byte in the top bits
  typedef logic [`LA_DIV_W-1:0] fdiv_t;

  // host opcodes
  typedef enum logic [7:0] {
    OP_STOP    = 8'h00,  // stop capture, clear overrun
    OP_RUN     = 8'h01,  // start capture
    OP_SET_DIV = 8'h80   // three divisor bytes follow
  } cmd_op_e;

  // decoder fsm
  typedef enum logic [1:0] {
    IDLE,  // waiting for an opcode
    DIV0,  // first divisor byte
    DIV1,
    DIV2   // last divisor byte
  } dec_state_e;

  // decoder to sampler
  typedef struct packed {
    fdiv_t fdiv;     // raw divisor
    logic  set_div;  // one-cycle load pulse
    logic  run;      // capture enable level
    logic  clr_ovr;  // one-cycle overrun clear
  } la_cfg_t;

endpackage

// ==== source/la_data_pkg.sv ====
// data side types shared by the sampler, the sample FIFO and the serializer
`include "la_defs.svh"

package la_data_pkg;

  typedef logic [7:0] byte_t;  // link byte

  typedef logic [`LA_CHLS-1:0] sample_t;  // one capture of all channels

  // one fifo entry
  typedef struct packed {
    sample_t data;  // captured channels
    logic    gap;   // samples were dropped before this one
  } smpl_beat_t;

  // serializer fsm
  typedef enum logic [1:0] {
    S_IDLE,  // nothing held
    S_HDR,   // header byte on the output
    S_DATA   // four data bytes, lsb first
  } ser_state_e;

endpackage

// ==== source/cmd_decoder.sv ====
// host command parser, turns link bytes into divisor loads and run/stop control for the sampler
`timescale 1ns/1ns
`include "la_defs.svh"

module cmd_decoder (
  input  logic                clk_i,
  input  logic                rst_in,       // sync, active low
  input  logic                cmd_valid_i,
  input  la_data_pkg::byte_t  cmd_data_i,
  output logic                cmd_ready_o,
  output la_cfg_pkg::la_cfg_t cfg_o
);

  import la_cfg_pkg::*;

  dec_state_e state_q;
  fdiv_t      fdiv_q;     // shift register, first byte ends up in the top bits
  logic       set_div_q;
  logic       run_q;
  logic       clr_ovr_q;
  logic       accept;
  cmd_op_e    op;

  assign cmd_ready_o = 1'b1;  // never back-pressures the link
  assign accept      = cmd_valid_i && cmd_ready_o;
  assign op          = cmd_op_e'(cmd_data_i);

  // divisor bytes are payload, no reset
  always_ff @(posedge clk_i) begin
    if (accept && state_q != IDLE) begin
      fdiv_q <= {fdiv_q[`LA_DIV_W-9:0], cmd_data_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q   <= IDLE;
      set_div_q <= 1'b0;
      run_q     <= 1'b0;
      clr_ovr_q <= 1'b0;
    end else begin
      set_div_q <= 1'b0;  // pulses by default low
      clr_ovr_q <= 1'b0;
      if (accept) begin
        case (state_q)
          IDLE: begin
            // opcodes only count here, divisor bytes may look like one
            case (op)
              OP_SET_DIV: state_q <= DIV0;
              OP_RUN:     run_q   <= 1'b1;
              OP_STOP: begin
                run_q     <= 1'b0;
                clr_ovr_q <= 1'b1;
              end
              default: ;  // unknown opcode dropped
            endcase
          end
          DIV0: state_q <= DIV1;
          DIV1: state_q <= DIV2;
          DIV2: begin
            state_q   <= IDLE;
            set_div_q <= 1'b1;  // fdiv_q complete in the same cycle
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  assign cfg_o = '{fdiv: fdiv_q, set_div: set_div_q, run: run_q, clr_ovr: clr_ovr_q};

  // each SET_DIV yields exactly one load pulse
  a_set_div_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    cfg_o.set_div |=> !cfg_o.set_div
  );

endmodule

// ==== source/sampler.sv ====
// divides the clock, captures all channels once per tick and flags drops when the FIFO is full
`timescale 1ns/1ns

module sampler (
  input  logic                   clk_i,
  input  logic                   rst_in,     // sync, active low
  input  la_cfg_pkg::la_cfg_t    cfg_i,
  input  la_data_pkg::sample_t   data_i,     // input channels
  input  logic                   full_i,     // fifo cannot take the beat
  output logic                   wr_valid_o, // one-cycle strobe, no stall
  output la_data_pkg::smpl_beat_t wr_beat_o,
  output logic                   overrun_o   // sticky until STOP
);

  import la_cfg_pkg::*;
  import la_data_pkg::*;

  fdiv_t   fdiv_swp;  // link byte order turned around
  fdiv_t   r_div;     // stored divisor
  fdiv_t   cnt;       // divider counter
  sample_t r_smpls;   // last capture
  logic    tick;
  logic    gap_q;     // a beat was dropped since the last stored one
  logic    ovr_q;

  // first received byte becomes bits 7:0
  assign fdiv_swp = {cfg_i.fdiv[7:0], cfg_i.fdiv[15:8], cfg_i.fdiv[23:16]};

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      r_div <= '0;
    end else if (cfg_i.set_div) begin
      r_div <= fdiv_swp;
    end
  end

  assign tick = cfg_i.run && (cnt >= r_div);  // >= covers a divisor shrinking mid count

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cnt        <= '0;
      wr_valid_o <= 1'b0;
    end else if (!cfg_i.run) begin
      cnt        <= '0;  // held while stopped
      wr_valid_o <= 1'b0;
    end else if (tick) begin
      cnt        <= '0;  // wrap, capture below
      wr_valid_o <= 1'b1;
    end else begin
      cnt        <= cnt + 1'b1;
      wr_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tick) begin
      r_smpls <= data_i;
    end
  end

  // drop bookkeeping
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      gap_q <= 1'b0;
      ovr_q <= 1'b0;
    end else begin
      if (wr_valid_o && full_i) begin
        gap_q <= 1'b1;  // mark the next stored beat
        ovr_q <= 1'b1;
      end else if (wr_valid_o) begin
        gap_q <= 1'b0;  // mark went out with this beat
      end
      if (cfg_i.clr_ovr) begin
        ovr_q <= 1'b0;  // STOP wins over a late drop
      end
    end
  end

  assign wr_beat_o = '{data: r_smpls, gap: gap_q};
  assign overrun_o = ovr_q;

  // with a divisor above zero strobes are at least two cycles apart
  a_stb_single: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    (wr_valid_o && r_div != '0) |=> !wr_valid_o
  );

  // load takes effect one cycle after the decoder pulse
  a_div_load: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    cfg_i.set_div |=> (r_div == $past(fdiv_swp))
  );

endmodule

// ==== source/sample_fifo.sv ====
// first-word-fall-through FIFO of sample beats between the sampler and the serializer
`timescale 1ns/1ns
`include "la_defs.svh"

module sample_fifo (
  input  logic                    clk_i,
  input  logic                    rst_in,     // sync, active low
  input  logic                    wr_valid_i,
  input  la_data_pkg::smpl_beat_t wr_beat_i,
  output logic                    full_o,
  output logic                    rd_valid_o,
  output la_data_pkg::smpl_beat_t rd_beat_o,
  input  logic                    rd_ready_i
);

  import la_data_pkg::*;

  localparam int unsigned DEPTH = 2 ** `LA_FIFO_AW;

  smpl_beat_t             mem [DEPTH];
  logic [`LA_FIFO_AW-1:0] wr_ptr;
  logic [`LA_FIFO_AW-1:0] rd_ptr;
  logic [`LA_FIFO_AW:0]   count;   // one extra bit for full
  logic                   do_wr;
  logic                   do_rd;

  assign full_o     = (count == DEPTH[`LA_FIFO_AW:0]);
  assign rd_valid_o = (count != '0);
  assign rd_beat_o  = mem[rd_ptr];  // head visible right after the write edge

  assign do_wr = wr_valid_i && !full_o;  // beat dropped otherwise
  assign do_rd = rd_valid_o && rd_ready_i;

  // storage, no reset
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither, level unchanged
      endcase
    end
  end

  // full and not popped, nothing may land
  a_no_wr_full: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    (full_o && !rd_ready_i) |=> (full_o && wr_ptr == $past(wr_ptr))
  );

  // empty, head pointer stays put whatever ready does
  a_no_rd_empty: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    !rd_valid_o |=> (rd_ptr == $past(rd_ptr))
  );

endmodule

// ==== source/sample_serializer.sv ====
// sends each sample beat as a header byte and four data bytes, least significant first
`timescale 1ns/1ns
`include "la_defs.svh"

module sample_serializer (
  input  logic                    clk_i,
  input  logic                    rst_in,     // sync, active low
  input  logic                    rd_valid_i,
  input  la_data_pkg::smpl_beat_t rd_beat_i,
  output logic                    rd_ready_o,
  output logic                    tx_valid_o,
  output la_data_pkg::byte_t      tx_data_o,
  input  logic                    tx_ready_i
);

  import la_data_pkg::*;

  ser_state_e state_q;
  smpl_beat_t hold_q;   // beat being sent
  logic [1:0] idx_q;    // data byte index
  logic       last_tx;  // last data byte leaves this cycle

  assign last_tx    = (state_q == S_DATA) && (idx_q == 2'd3) && tx_ready_i;
  // pop when empty or as the last byte goes, keeps samples back to back
  assign rd_ready_o = (state_q == S_IDLE) || last_tx;
  assign tx_valid_o = (state_q != S_IDLE);

  always_comb begin
    case (state_q)
      S_HDR:   tx_data_o = hold_q.gap ? `LA_HDR_GAP : `LA_HDR_OK;
      S_DATA:  tx_data_o = hold_q.data[idx_q*8 +: 8];
      default: tx_data_o = '0;
    endcase
  end

  // holding register, payload only
  always_ff @(posedge clk_i) begin
    if (rd_valid_i && rd_ready_o) begin
      hold_q <= rd_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rd_valid_i) begin
            state_q <= S_HDR;
          end
        end
        S_HDR: begin
          if (tx_ready_i) begin
            state_q <= S_DATA;
            idx_q   <= '0;
          end
        end
        S_DATA: begin
          if (last_tx) begin
            state_q <= rd_valid_i ? S_HDR : S_IDLE;  // next header if a beat waits
          end else if (tx_ready_i) begin
            idx_q <= idx_q + 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // stalled byte must not change under the receiver
  a_tx_stable: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    (tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_data_o))
  );

endmodule

// ==== source/la_core.sv ====
// capture path top level, command decoder into sampler, FIFO and byte serializer
`timescale 1ns/1ns

module la_core (
  input  logic                 clk_i,
  input  logic                 rst_in,       // sync, active low
  // host commands
  input  logic                 cmd_valid_i,
  input  la_data_pkg::byte_t   cmd_data_i,
  output logic                 cmd_ready_o,
  // probed channels
  input  la_data_pkg::sample_t data_i,
  // sample bytes back to the host
  output logic                 tx_valid_o,
  output la_data_pkg::byte_t   tx_data_o,
  input  logic                 tx_ready_i,
  output logic                 overrun_o     // sticky drop flag
);

  import la_cfg_pkg::*;
  import la_data_pkg::*;

  la_cfg_t    cfg;
  logic       wr_valid;
  smpl_beat_t wr_beat;
  logic       full;
  logic       rd_valid;
  smpl_beat_t rd_beat;
  logic       rd_ready;

  cmd_decoder cmd_decoder_i (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .cfg_o       (cfg)
  );

  sampler sampler_i (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cfg_i      (cfg),
    .data_i     (data_i),
    .full_i     (full),
    .wr_valid_o (wr_valid),
    .wr_beat_o  (wr_beat),
    .overrun_o  (overrun_o)
  );

  sample_fifo sample_fifo_i (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .wr_valid_i (wr_valid),
    .wr_beat_i  (wr_beat),
    .full_o     (full),
    .rd_valid_o (rd_valid),
    .rd_beat_o  (rd_beat),
    .rd_ready_i (rd_ready)
  );

  sample_serializer sample_serializer_i (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .rd_valid_i (rd_valid),
    .rd_beat_i  (rd_beat),
    .rd_ready_o (rd_ready),
    .tx_valid_o (tx_valid_o),
    .tx_data_o  (tx_data_o),
    .tx_ready_i (tx_ready_i)
  );

endmodule

// ==== dv/la_core_tb.sv ====
// self-checking testbench for la_core, runs divisor, back-pressure, overrun and stop phases
`timescale 1ns/1ns
`include "la_defs.svh"

module la_core_tb;

  import la_cfg_pkg::*;
  import la_data_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;  // whole run needs roughly 2500 cycles
  localparam logic [31:0] SEED = 32'd47025;

  // one received group plus the phase it belongs to
  typedef struct packed {
    byte_t                hdr;
    sample_t              word;      // rebuilt lsb first
    logic [`LA_DIV_W-1:0] div;       // divisor of the phase
    logic                 drops_ok;  // fifo may overflow here
    logic                 carry;     // gap left over from the last phase
    logic                 first;     // first group after RUN
  } grp_t;

  logic    clk_i;
  logic    rst_in;
  logic    cmd_valid_i;
  byte_t   cmd_data_i;
  logic    cmd_ready_o;
  sample_t data_i;
  logic    tx_valid_o;
  byte_t   tx_data_o;
  logic    tx_ready_i;
  logic    overrun_o;

  logic [31:0]          rng;
  int                   ready_pct;  // percent of cycles with tx_ready_i high
  logic [`LA_DIV_W-1:0] div_cur;
  logic                 drops_cur;
  logic                 carry_cur;
  logic                 prev_drops = 1'b0;
  int                   phase_id   = 0;
  int                   last_phase = 0;
  grp_t                 grp_q[$];
  byte_t                grp_bytes[5];
  int                   byte_idx    = 0;
  int                   group_cnt   = 0;  // collected
  int                   gap_cnt     = 0;
  int                   gap_before;
  logic                 stall_q = 1'b0;
  byte_t                data_q;
  sample_t              prev_word;
  int                   cycle_cnt = 0;

  la_core la_core_i (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .data_i      (data_i),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o),
    .tx_ready_i  (tx_ready_i),
    .overrun_o   (overrun_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference model, captures are divisor plus one cycles apart
  function automatic sample_t ref_next_sample(input sample_t prev,
                                              input logic [`LA_DIV_W-1:0] div);
    return prev + {8'h00, div} + 32'd1;
  endfunction

  task automatic halt_failed();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string why);
    $display("ERROR at %0t: %s", $time, why);
    halt_failed();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL time=%0t signal=%s expected=0x%08h actual=0x%08h",
               $time, name, expected, actual);
      halt_failed();
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // free-running channel count and random ready, both on the falling edge
  always @(negedge clk_i) begin
    data_i     = data_i + 1'b1;
    rng        = xorshift32(rng);
    tx_ready_i = ((rng % 100) < ready_pct);
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_error($sformatf("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // byte monitor, stall hold check and group assembly
  always @(posedge clk_i) begin
    if (rst_in) begin
      if (stall_q) begin
        check_value("tx_valid_o", 1, tx_valid_o);  // valid may not drop while stalled
        check_value("tx_data_o", data_q, tx_data_o);
      end
      stall_q = tx_valid_o && !tx_ready_i;
      data_q  = tx_data_o;
      if (tx_valid_o && tx_ready_i) begin
        grp_bytes[byte_idx] = tx_data_o;
        byte_idx++;
        if (byte_idx == 5) begin
          grp_q.push_back('{hdr: grp_bytes[0],
                            word: {grp_bytes[4], grp_bytes[3], grp_bytes[2], grp_bytes[1]},
                            div: div_cur, drops_ok: drops_cur, carry: carry_cur,
                            first: (phase_id != last_phase)});
          last_phase = phase_id;
          group_cnt++;
          byte_idx = 0;
        end
      end
    end
  end

  task automatic compare_group(input grp_t g);
    sample_t     exp_word;
    logic [31:0] diff;
    logic [31:0] step;
    step     = {8'h00, g.div} + 32'd1;
    exp_word = ref_next_sample(prev_word, g.div);
    diff     = g.word - prev_word;
    if (g.first) begin
      if (!(g.carry && g.hdr == `LA_HDR_GAP)) begin
        check_value("header", `LA_HDR_OK, g.hdr);  // no earlier sample to diff against
      end
    end else if (g.hdr == `LA_HDR_OK || !g.drops_ok) begin
      check_value("header", `LA_HDR_OK, g.hdr);
      check_value("sample word", exp_word, g.word);
    end else begin
      // samples went missing, spacing a whole number of steps above one
      check_value("header", `LA_HDR_GAP, g.hdr);
      check_value("gap spacing remainder", 0, diff % step);
      check_value("gap spacing above one step", 1, diff > step);
      gap_cnt++;
    end
    prev_word = g.word;
  endtask

  always @(negedge clk_i) begin
    while (grp_q.size() > 0) begin
      compare_group(grp_q.pop_front());
    end
  end

  task automatic send_byte(input byte_t b);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_data_i  = b;
    @(posedge clk_i);
    while (!cmd_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  // divisor bytes lsb first on the link
  task automatic set_divisor(input logic [`LA_DIV_W-1:0] d);
    send_byte(OP_SET_DIV);
    send_byte(d[7:0]);
    send_byte(d[15:8]);
    send_byte(d[23:16]);
  endtask

  task automatic wait_drain();
    int idle;
    idle = 0;
    while (idle < 8) begin
      @(negedge clk_i);
      idle = tx_valid_o ? 0 : idle + 1;
    end
  endtask

  task automatic run_phase(input logic [`LA_DIV_W-1:0] div, input int pct,
                           input logic drops_ok, input int n_groups, input int stall);
    int target;
    int seen;
    set_divisor(div);
    div_cur    = div;
    drops_cur  = drops_ok;
    carry_cur  = prev_drops;
    prev_drops = drops_ok;
    phase_id++;
    ready_pct  = (stall > 0) ? 0 : pct;
    target     = group_cnt + n_groups;
    send_byte(OP_RUN);
    if (stall > 0) begin
      repeat (stall) @(negedge clk_i);  // fifo full, later samples dropped
      check_value("overrun_o", 1, overrun_o);
      ready_pct = pct;
    end
    while (group_cnt < target) @(negedge clk_i);
    send_byte(OP_STOP);
    repeat (2) @(negedge clk_i);
    check_value("overrun_o", 0, overrun_o);
    wait_drain();
    seen = group_cnt;
    repeat (60) @(negedge clk_i);
    check_value("groups after drain", seen, group_cnt);
    check_value("bytes of a partial group", 0, byte_idx);
  endtask

  initial begin
    rst_in      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_data_i  = '0;
    data_i      = '0;
    tx_ready_i  = 1'b0;
    rng         = SEED;
    ready_pct   = 100;
    div_cur     = '0;
    drops_cur   = 1'b0;
    carry_cur   = 1'b0;
    prev_word   = '0;
    repeat (16) @(negedge clk_i);
    rst_in = 1'b1;
    repeat (40) begin  // idle before any RUN
      @(negedge clk_i);
      check_value("tx_valid_o", 0, tx_valid_o);
      check_value("overrun_o", 0, overrun_o);
      check_value("cmd_ready_o", 1, cmd_ready_o);
    end
    run_phase(24'd17, 100, 1'b0, 12, 0);
    run_phase(24'd3, 100, 1'b0, 12, 0);
    run_phase(24'd0, 100, 1'b1, 12, 0);   // faster than the link, drops expected
    run_phase(24'd17, 80, 1'b0, 20, 0);   // random stalls, no overflow
    gap_before = gap_cnt;
    run_phase(24'd17, 100, 1'b1, 16, 300);
    if (gap_cnt == gap_before) begin
      report_error("overrun phase delivered no gap header");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/la_cfg_pkg.sv
source/la_data_pkg.sv
source/cmd_decoder.sv
source/sampler.sv
source/sample_fifo.sv
source/sample_serializer.sv
source/la_core.sv
dv/la_core_tb.sv

// ==== Bender.yml ====
package:
  name: la_core

sources:
  - include_dirs:
      - source
    files:
      - source/la_cfg_pkg.sv
      - source/la_data_pkg.sv
      - source/cmd_decoder.sv
      - source/sampler.sv
      - source/sample_fifo.sv
      - source/sample_serializer.sv
      - source/la_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/la_core_tb.sv
